// File: common/cpi_pix_pkg.sv
`default_nettype none

package cpi_pix_pkg;

    // camera side
    typedef logic [7:0] cam_byte_t;

    // colour channel, left-aligned with zero fill
    typedef logic [7:0] chan_t;

    // row or column position inside a frame
    typedef logic [15:0] coord_t;

    // r*cr + g*cg + b*cb, truncated to 17 bits
    typedef logic [16:0] filt_sum_t;

    // word towards the output port
    typedef logic [31:0] pix_word_t;

    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } rgb_t;

    // two bytes captured on one line, first is the earlier one
    typedef struct packed {
        cam_byte_t first;
        cam_byte_t second;
    } cpi_pair_t;

endpackage

`default_nettype wire

// File: common/cpi_cfg_pkg.sv
`default_nettype none

package cpi_cfg_pkg;

    import cpi_pix_pkg::*;

    // unused codes fall back to little endian bypass
    typedef enum logic [2:0] {
        FMT_RGB565     = 3'b000,
        FMT_RGB555     = 3'b001,
        FMT_RGB444     = 3'b010,
        FMT_BYP_LITEND = 3'b100,
        FMT_BYP_BIGEND = 3'b101
    } cpi_format_e;

    typedef logic [7:0] coeff_t;

    // 0..9 used, anything above behaves as 0
    typedef logic [3:0] shift_t;

    typedef logic [5:0] drop_cnt_t;

    // only changed while enable is low
    typedef struct packed {
        logic        enable;
        logic        vsync_pol;  // 1 inverts cam vsync
        logic        drop_en;
        drop_cnt_t   drop_val;   // keep one frame out of drop_val+1
        logic        slice_en;
        cpi_format_e format;
        shift_t      shift;
        coord_t      row_len;    // last column index of a row
        coord_t      llx;
        coord_t      lly;
        coord_t      urx;
        coord_t      ury;
        coeff_t      coeff_r;
        coeff_t      coeff_g;
        coeff_t      coeff_b;
    } cpi_cfg_t;

endpackage

`default_nettype wire

// File: verilog/cpi_frame_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cpi_frame_ctrl (
    input  logic                  s_cam_clk_dft,
    input  logic                  rstn_i,
    input  cpi_cfg_pkg::cpi_cfg_t cfg_i,
    input  logic                  cam_vsync_i,
    output logic                  active_o,
    output logic                  frame_ok_o,
    output logic                  sof_o
);

    import cpi_cfg_pkg::*;

    logic [1:0] en_sync_q;
    logic       en_s;
    logic       vsync_adj;
    logic       vsync_q;
    logic       active_q;
    drop_cnt_t  frame_cnt_q;

    assign en_s      = en_sync_q[1];
    assign vsync_adj = cam_vsync_i ^ cfg_i.vsync_pol;
    assign sof_o     = vsync_adj & ~vsync_q & en_s;  // rising edge of adjusted vsync

    assign active_o   = active_q;
    assign frame_ok_o = active_q & (frame_cnt_q == '0);

    always_ff @(posedge s_cam_clk_dft or negedge rstn_i) begin
        if (!rstn_i) begin
            en_sync_q <= 2'b00;
        end else begin
            en_sync_q <= {en_sync_q[0], cfg_i.enable};
        end
    end

    always_ff @(posedge s_cam_clk_dft or negedge rstn_i) begin
        if (!rstn_i) begin
            vsync_q <= 1'b0;
        end else if (en_s) begin
            vsync_q <= vsync_adj;
        end
    end

    // capture starts on a frame boundary, stops at once
    always_ff @(posedge s_cam_clk_dft or negedge rstn_i) begin
        if (!rstn_i) begin
            active_q <= 1'b0;
        end else if (!en_s) begin
            active_q <= 1'b0;
        end else if (sof_o) begin
            active_q <= 1'b1;
        end
    end

    always_ff @(posedge s_cam_clk_dft or negedge rstn_i) begin
        if (!rstn_i) begin
            frame_cnt_q <= '0;
        end else if (!en_s) begin
            frame_cnt_q <= '0;  // first frame after enable is kept
        end else if (sof_o && active_q) begin
            if (cfg_i.drop_en && (frame_cnt_q != cfg_i.drop_val)) begin
                frame_cnt_q <= frame_cnt_q + 6'd1;
            end else begin
                frame_cnt_q <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/cpi_sampler.sv
`timescale 1ns/1ps
`default_nettype none

module cpi_sampler (
    input  logic                   s_cam_clk_dft,
    input  logic                   rstn_i,
    input  cpi_cfg_pkg::cpi_cfg_t  cfg_i,
    input  cpi_pix_pkg::cam_byte_t cam_data_i,
    input  logic                   cam_hsync_i,
    input  logic                   active_i,
    input  logic                   frame_ok_i,
    input  logic                   sof_i,
    output cpi_pix_pkg::cpi_pair_t pair_o,
    output logic                   pair_valid_o
);

    import cpi_pix_pkg::*;

    logic      phase_first_q;
    cam_byte_t first_q;
    coord_t    col_q;
    coord_t    row_q;
    logic      line_on;
    logic      second_byte;
    logic      in_window;

    assign line_on     = cam_hsync_i & active_i;
    assign second_byte = line_on & ~phase_first_q;

    assign in_window = ~cfg_i.slice_en |
                       ((col_q >= cfg_i.llx) && (col_q <= cfg_i.urx) &&
                        (row_q >= cfg_i.lly) && (row_q <= cfg_i.ury));

    // second byte goes straight through, registered downstream
    assign pair_o       = '{first: first_q, second: cam_data_i};
    assign pair_valid_o = second_byte & frame_ok_i & in_window;

    always_ff @(posedge s_cam_clk_dft or negedge rstn_i) begin
        if (!rstn_i) begin
            phase_first_q <= 1'b1;
        end else if (!line_on) begin
            phase_first_q <= 1'b1;  // realign on every line
        end else begin
            phase_first_q <= ~phase_first_q;
        end
    end

    always_ff @(posedge s_cam_clk_dft) begin
        if (line_on && phase_first_q) begin
            first_q <= cam_data_i;
        end
    end

    always_ff @(posedge s_cam_clk_dft or negedge rstn_i) begin
        if (!rstn_i) begin
            col_q <= '0;
            row_q <= '0;
        end else if (sof_i || !active_i) begin
            col_q <= '0;
            row_q <= '0;
        end else if (second_byte && cfg_i.slice_en) begin
            if (col_q == cfg_i.row_len) begin
                col_q <= '0;
                row_q <= row_q + 16'd1;
            end else begin
                col_q <= col_q + 16'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: pixel_pipe/cpi_pixel_format.sv
`timescale 1ns/1ps
`default_nettype none

module cpi_pixel_format (
    input  logic                   s_cam_clk_dft,
    input  logic                   rstn_i,
    input  cpi_cfg_pkg::cpi_cfg_t  cfg_i,
    input  cpi_pix_pkg::cpi_pair_t pair_i,
    input  logic                   pair_valid_i,
    output cpi_pix_pkg::rgb_t      rgb_o,
    output logic                   rgb_valid_o,
    output cpi_pix_pkg::pix_word_t byp_o,
    output logic                   byp_valid_o
);

    import cpi_cfg_pkg::*;
    import cpi_pix_pkg::*;

    rgb_t        rgb_d;
    logic [15:0] byp_d;
    logic        is_rgb;

    always_comb begin
        rgb_d  = '0;
        byp_d  = {pair_i.first, pair_i.second};  // little endian unless overridden
        is_rgb = 1'b1;
        case (cfg_i.format)
            FMT_RGB565: begin
                rgb_d.r = {pair_i.first[7:3], 3'b000};
                rgb_d.g = {pair_i.first[2:0], pair_i.second[7:5], 2'b00};
                rgb_d.b = {pair_i.second[4:0], 3'b000};
            end
            FMT_RGB555: begin
                rgb_d.r = {pair_i.first[6:2], 3'b000};
                rgb_d.g = {pair_i.first[1:0], pair_i.second[7:5], 3'b000};
                rgb_d.b = {pair_i.second[4:0], 3'b000};
            end
            FMT_RGB444: begin
                rgb_d.r = {pair_i.first[3:0], 4'b0000};
                rgb_d.g = {pair_i.second[7:4], 4'b0000};
                rgb_d.b = {pair_i.second[3:0], 4'b0000};
            end
            FMT_BYP_BIGEND: begin
                is_rgb = 1'b0;
                byp_d  = {pair_i.second, pair_i.first};
            end
            default: is_rgb = 1'b0;
        endcase
    end

    always_ff @(posedge s_cam_clk_dft or negedge rstn_i) begin
        if (!rstn_i) begin
            rgb_valid_o <= 1'b0;
            byp_valid_o <= 1'b0;
        end else begin
            rgb_valid_o <= pair_valid_i & is_rgb;
            byp_valid_o <= pair_valid_i & ~is_rgb;
        end
    end

    always_ff @(posedge s_cam_clk_dft) begin
        if (pair_valid_i && is_rgb) begin
            rgb_o <= rgb_d;
        end
        if (pair_valid_i && !is_rgb) begin
            byp_o <= pix_word_t'(byp_d);
        end
    end

endmodule

`default_nettype wire

// File: pixel_pipe/cpi_luma_filter.sv
`timescale 1ns/1ps
`default_nettype none

module cpi_luma_filter (
    input  logic                   s_cam_clk_dft,
    input  logic                   rstn_i,
    input  cpi_cfg_pkg::cpi_cfg_t  cfg_i,
    input  cpi_pix_pkg::rgb_t      rgb_i,
    input  logic                   rgb_valid_i,
    input  cpi_pix_pkg::pix_word_t byp_i,
    input  logic                   byp_valid_i,
    output cpi_pix_pkg::pix_word_t word_o,
    output logic                   word_valid_o
);

    import cpi_pix_pkg::*;

    logic [15:0] prod_r;
    logic [15:0] prod_g;
    logic [15:0] prod_b;
    filt_sum_t   sum_d;
    filt_sum_t   sum_q;
    logic        sum_valid_q;
    filt_sum_t   sum_shr;

    assign prod_r = rgb_i.r * cfg_i.coeff_r;
    assign prod_g = rgb_i.g * cfg_i.coeff_g;
    assign prod_b = rgb_i.b * cfg_i.coeff_b;
    assign sum_d  = filt_sum_t'(prod_r) + filt_sum_t'(prod_g) + filt_sum_t'(prod_b);

    // shifts above 9 pass the sum unshifted
    assign sum_shr = (cfg_i.shift > 4'd9) ? sum_q : (sum_q >> cfg_i.shift);

    always_ff @(posedge s_cam_clk_dft or negedge rstn_i) begin
        if (!rstn_i) begin
            sum_valid_q  <= 1'b0;
            word_valid_o <= 1'b0;
        end else begin
            sum_valid_q  <= rgb_valid_i;
            word_valid_o <= sum_valid_q | byp_valid_i;
        end
    end

    always_ff @(posedge s_cam_clk_dft) begin
        if (rgb_valid_i) begin
            sum_q <= sum_d;
        end
        if (sum_valid_q) begin
            word_o <= pix_word_t'(sum_shr[15:0]);
        end else if (byp_valid_i) begin
            word_o <= byp_i;
        end
    end

endmodule

`default_nettype wire

// File: verilog/cpi_out_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module cpi_out_fifo #(
    parameter int unsigned FIFO_DEPTH = 8
) (
    input  logic                   s_cam_clk_dft,
    input  logic                   rstn_i,
    input  logic                   flush_i,
    input  cpi_pix_pkg::pix_word_t wr_data_i,
    input  logic                   wr_valid_i,
    output cpi_pix_pkg::pix_word_t rd_data_o,
    output logic                   rd_valid_o,
    input  logic                   rd_ready_i,
    output logic                   overflow_o
);

    import cpi_pix_pkg::*;

    localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

    pix_word_t        mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             full;
    logic             wr_en;
    logic             rd_en;

    assign full       = (count_q == CNT_W'(FIFO_DEPTH));
    assign wr_en      = wr_valid_i & ~full & ~flush_i;
    assign rd_en      = rd_valid_o & rd_ready_i;
    assign rd_valid_o = (count_q != '0);
    assign rd_data_o  = mem[rd_ptr_q];

    always_ff @(posedge s_cam_clk_dft or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            overflow_o <= 1'b0;
        end else if (flush_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (rd_en) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(wr_en) - CNT_W'(rd_en);
            if (wr_valid_i && full) begin
                overflow_o <= 1'b1;  // word lost, camera can't stall
            end
        end
    end

    always_ff @(posedge s_cam_clk_dft) begin
        if (wr_en) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
    end

endmodule

`default_nettype wire

// File: verilog/cpi_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpi_top #(
    parameter int unsigned FIFO_DEPTH = 8
) (
    input  logic                   s_cam_clk_dft,
    input  logic                   rstn_i,
    input  cpi_cfg_pkg::cpi_cfg_t  cfg_i,
    input  cpi_pix_pkg::cam_byte_t cam_data_i,
    input  logic                   cam_hsync_i,
    input  logic                   cam_vsync_i,
    output cpi_pix_pkg::pix_word_t out_data_o,
    output logic                   out_valid_o,
    input  logic                   out_ready_i,
    output logic                   overflow_o,
    output logic                   frame_evt_o
);

    import cpi_pix_pkg::*;

    logic      active;
    logic      frame_ok;
    logic      sof;

    cpi_pair_t pair;
    logic      pair_valid;

    rgb_t      rgb;
    logic      rgb_valid;
    pix_word_t byp;
    logic      byp_valid;

    pix_word_t word;
    logic      word_valid;

    assign frame_evt_o = sof;

    cpi_frame_ctrl u_frame_ctrl (
        .s_cam_clk_dft ( s_cam_clk_dft ),
        .rstn_i        ( rstn_i        ),
        .cfg_i         ( cfg_i         ),
        .cam_vsync_i   ( cam_vsync_i   ),
        .active_o      ( active        ),
        .frame_ok_o    ( frame_ok      ),
        .sof_o         ( sof           )
    );

    cpi_sampler u_sampler (
        .s_cam_clk_dft ( s_cam_clk_dft ),
        .rstn_i        ( rstn_i        ),
        .cfg_i         ( cfg_i         ),
        .cam_data_i    ( cam_data_i    ),
        .cam_hsync_i   ( cam_hsync_i   ),
        .active_i      ( active        ),
        .frame_ok_i    ( frame_ok      ),
        .sof_i         ( sof           ),
        .pair_o        ( pair          ),
        .pair_valid_o  ( pair_valid    )
    );

    cpi_pixel_format u_pixel_format (
        .s_cam_clk_dft ( s_cam_clk_dft ),
        .rstn_i        ( rstn_i        ),
        .cfg_i         ( cfg_i         ),
        .pair_i        ( pair          ),
        .pair_valid_i  ( pair_valid    ),
        .rgb_o         ( rgb           ),
        .rgb_valid_o   ( rgb_valid     ),
        .byp_o         ( byp           ),
        .byp_valid_o   ( byp_valid     )
    );

    cpi_luma_filter u_luma_filter (
        .s_cam_clk_dft ( s_cam_clk_dft ),
        .rstn_i        ( rstn_i        ),
        .cfg_i         ( cfg_i         ),
        .rgb_i         ( rgb           ),
        .rgb_valid_i   ( rgb_valid     ),
        .byp_i         ( byp           ),
        .byp_valid_i   ( byp_valid     ),
        .word_o        ( word          ),
        .word_valid_o  ( word_valid    )
    );

    cpi_out_fifo #(
        .FIFO_DEPTH ( FIFO_DEPTH )
    ) u_out_fifo (
        .s_cam_clk_dft ( s_cam_clk_dft ),
        .rstn_i        ( rstn_i        ),
        .flush_i       ( ~cfg_i.enable ),  // drop stored words while disabled
        .wr_data_i     ( word          ),
        .wr_valid_i    ( word_valid    ),
        .rd_data_o     ( out_data_o    ),
        .rd_valid_o    ( out_valid_o   ),
        .rd_ready_i    ( out_ready_i   ),
        .overflow_o    ( overflow_o    )
    );

endmodule

`default_nettype wire

// File: tb/cpi_tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module cpi_tb_clkgen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

// File: tb/cpi_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpi_tb;

    import cpi_cfg_pkg::*;
    import cpi_pix_pkg::*;

    localparam int FIFO_DEPTH = 8;
    localparam int NUM_SCEN   = 10;

    typedef struct packed {
        cpi_format_e fmt;
        int          cr;
        int          cg;
        int          cb;
        int          sh;
        int          slice;
        int          llx;
        int          lly;
        int          urx;
        int          ury;
        int          row_len;
        int          drop;
        int          drop_val;
        int          pol;
        int          en;
        int          frames;
        int          lines;
        int          ppl;   // pairs per line
        int          hold;  // ready low while frames are sent
    } scen_t;

    logic      s_cam_clk_dft;
    logic      rstn_i;
    cpi_cfg_t  cfg_i;
    cam_byte_t cam_data_i;
    logic      cam_hsync_i;
    logic      cam_vsync_i;
    pix_word_t out_data_o;
    logic      out_valid_o;
    logic      out_ready_i;
    logic      overflow_o;
    logic      frame_evt_o;

    integer    seed = 32'h4366;
    scen_t     tbl [NUM_SCEN];
    pix_word_t exp_q [$];
    int        err_word;
    int        err_flag;
    int        err_count;
    int        err_other;
    int        evt_cnt;
    int        words_seen;
    int        exp_words;
    logic      exp_ovf;

    cpi_tb_clkgen #(
        .PERIOD_NS ( 40 )
    ) u_clkgen (
        .clk_o ( s_cam_clk_dft )
    );

    cpi_top #(
        .FIFO_DEPTH ( FIFO_DEPTH )
    ) UUT (
        .s_cam_clk_dft ( s_cam_clk_dft ),
        .rstn_i        ( rstn_i        ),
        .cfg_i         ( cfg_i         ),
        .cam_data_i    ( cam_data_i    ),
        .cam_hsync_i   ( cam_hsync_i   ),
        .cam_vsync_i   ( cam_vsync_i   ),
        .out_data_o    ( out_data_o    ),
        .out_valid_o   ( out_valid_o   ),
        .out_ready_i   ( out_ready_i   ),
        .overflow_o    ( overflow_o    ),
        .frame_evt_o   ( frame_evt_o   )
    );

    task automatic check_word(input pix_word_t got, input pix_word_t exp, input string what);
        if (got !== exp) begin
            err_word++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            err_flag++;
            $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            err_count++;
            $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // channels left-aligned, sum kept to 17 bits, then shifted
    function automatic pix_word_t model_word(input scen_t s, input cam_byte_t b0,
                                             input cam_byte_t b1);
        int r;
        int g;
        int b;
        int sum;
        int sh;
        case (s.fmt)
            FMT_RGB565: begin
                r = int'(b0[7:3]) * 8;
                g = int'({b0[2:0], b1[7:5]}) * 4;
                b = int'(b1[4:0]) * 8;
            end
            FMT_RGB555: begin
                r = int'(b0[6:2]) * 8;
                g = int'({b0[1:0], b1[7:5]}) * 8;
                b = int'(b1[4:0]) * 8;
            end
            FMT_RGB444: begin
                r = int'(b0[3:0]) * 16;
                g = int'(b1[7:4]) * 16;
                b = int'(b1[3:0]) * 16;
            end
            FMT_BYP_BIGEND: return pix_word_t'({b1, b0});
            default: return pix_word_t'({b0, b1});
        endcase
        sum = (r * s.cr + g * s.cg + b * s.cb) % (1 << 17);
        sh  = (s.sh > 9) ? 0 : s.sh;
        return pix_word_t'((sum >> sh) % (1 << 16));
    endfunction

    function automatic int row_cycles(input scen_t s);
        return 30 + s.frames * (12 + s.lines * (2 * s.ppl + 4));
    endfunction

    task automatic fill_table();
        //          fmt             cr   cg   cb  sh sl lx ly ux uy rl dr dv pl en fr ln pp hd
        tbl[0] = '{FMT_RGB565,     77, 150,  29,  8, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 2, 3, 6, 0};
        tbl[1] = '{FMT_RGB555,     33,  64,  12,  0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1, 3, 5, 0};
        tbl[2] = '{FMT_RGB444,    255, 255, 255,  9, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 2, 6, 0};
        tbl[3] = '{FMT_RGB565,    200,  17,  99, 12, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1, 2, 6, 0};
        tbl[4] = '{FMT_BYP_LITEND,  0,   0,   0,  0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 2, 6, 0};
        tbl[5] = '{FMT_BYP_BIGEND,  0,   0,   0,  0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1, 2, 6, 0};
        tbl[6] = '{FMT_RGB565,     10,  20,  30,  3, 1, 1, 1, 3, 2, 5, 0, 0, 0, 1, 1, 4, 6, 0};
        tbl[7] = '{FMT_BYP_LITEND,  0,   0,   0,  0, 0, 0, 0, 0, 0, 0, 1, 2, 0, 1, 7, 2, 3, 0};
        tbl[8] = '{FMT_BYP_BIGEND,  0,   0,   0,  0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 2, 6, 1};
        tbl[9] = '{FMT_RGB444,      5,   6,   7,  2, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 2, 2, 4, 0};
    endtask

    task automatic send_frame(input scen_t s, input int fidx);
        int        col;
        int        row;
        cam_byte_t b0;
        cam_byte_t b1;
        logic      keep;
        logic      in_win;
        keep = (s.en != 0) && ((s.drop == 0) || (fidx % (s.drop_val + 1) == 0));
        col  = 0;
        row  = 0;
        @(negedge s_cam_clk_dft);
        cam_vsync_i = (s.pol == 0);  // adjusted vsync high
        repeat (2) @(negedge s_cam_clk_dft);
        cam_vsync_i = (s.pol != 0);
        repeat (3) @(negedge s_cam_clk_dft);
        for (int l = 0; l < s.lines; l++) begin
            for (int p = 0; p < s.ppl; p++) begin
                b0 = cam_byte_t'($random(seed));
                b1 = cam_byte_t'($random(seed));
                cam_hsync_i = 1'b1;
                cam_data_i  = b0;
                @(negedge s_cam_clk_dft);
                cam_data_i = b1;
                in_win = (s.slice == 0) ||
                         (col >= s.llx && col <= s.urx && row >= s.lly && row <= s.ury);
                if (keep && in_win) begin
                    if ((s.hold != 0) && (exp_words >= FIFO_DEPTH)) begin
                        exp_ovf = 1'b1;  // fifo full, word lost
                    end else begin
                        exp_q.push_back(model_word(s, b0, b1));
                        exp_words++;
                    end
                end
                if (s.slice != 0) begin
                    if (col == s.row_len) begin
                        col = 0;
                        row++;
                    end else begin
                        col++;
                    end
                end
                @(negedge s_cam_clk_dft);
            end
            cam_hsync_i = 1'b0;
            repeat (4) @(negedge s_cam_clk_dft);
        end
        repeat (6) @(negedge s_cam_clk_dft);
    endtask

    task automatic run_scenario(input scen_t s, input int idx);
        cpi_cfg_t cfg;
        int       waited;
        cfg           = '0;
        cfg.vsync_pol = (s.pol != 0);
        cfg.drop_en   = (s.drop != 0);
        cfg.drop_val  = drop_cnt_t'(s.drop_val);
        cfg.slice_en  = (s.slice != 0);
        cfg.format    = s.fmt;
        cfg.shift     = shift_t'(s.sh);
        cfg.row_len   = coord_t'(s.row_len);
        cfg.llx       = coord_t'(s.llx);
        cfg.lly       = coord_t'(s.lly);
        cfg.urx       = coord_t'(s.urx);
        cfg.ury       = coord_t'(s.ury);
        cfg.coeff_r   = coeff_t'(s.cr);
        cfg.coeff_g   = coeff_t'(s.cg);
        cfg.coeff_b   = coeff_t'(s.cb);
        @(negedge s_cam_clk_dft);
        cfg_i       = cfg;
        cam_vsync_i = (s.pol != 0);
        out_ready_i = (s.hold == 0);
        evt_cnt     = 0;
        words_seen  = 0;
        exp_words   = 0;
        exp_ovf     = 1'b0;
        @(negedge s_cam_clk_dft);
        cfg_i.enable = (s.en != 0);
        repeat (3) @(negedge s_cam_clk_dft);
        for (int f = 0; f < s.frames; f++) begin
            send_frame(s, f);
        end
        repeat (8) @(negedge s_cam_clk_dft);
        if (s.hold != 0) begin
            check_flag(overflow_o, exp_ovf, $sformatf("scenario %0d overflow_o", idx));
            out_ready_i = 1'b1;
        end
        waited = 0;
        while (exp_q.size() != 0 && waited < 100) begin
            @(negedge s_cam_clk_dft);
            waited++;
        end
        if (exp_q.size() != 0) begin
            err_other++;
            $display("scenario %0d: %0d expected words never came out", idx, exp_q.size());
            exp_q.delete();
        end
        repeat (4) @(negedge s_cam_clk_dft);
        check_count(words_seen, exp_words, $sformatf("scenario %0d words", idx));
        check_count(evt_cnt, (s.en != 0) ? s.frames : 0,
                    $sformatf("scenario %0d frame events", idx));
        check_flag(overflow_o, exp_ovf, $sformatf("scenario %0d overflow_o at end", idx));
        cfg_i.enable = 1'b0;
        repeat (2) @(negedge s_cam_clk_dft);
        check_flag(overflow_o, 1'b0, $sformatf("scenario %0d overflow_o after disable", idx));
    endtask

    // outputs sampled at the rising edge, inputs move on the falling one
    always @(posedge s_cam_clk_dft) begin
        if (rstn_i) begin
            if (frame_evt_o) begin
                evt_cnt++;
            end
            if (out_valid_o && out_ready_i) begin
                words_seen++;
                if (exp_q.size() == 0) begin
                    err_other++;
                    $display("unexpected output word %h at %0t", out_data_o, $time);
                end else begin
                    check_word(out_data_o, exp_q.pop_front(), "out_data_o");
                end
            end
        end
    end

    initial begin
        int cycles;
        @(posedge rstn_i);
        cycles = 0;
        for (int i = 0; i < NUM_SCEN; i++) begin
            cycles += row_cycles(tbl[i]);
        end
        repeat (2 * cycles + 1000) @(posedge s_cam_clk_dft);
        $display("timeout: the run did not finish within %0d cycles", 2 * cycles + 1000);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        rstn_i      = 1'b0;
        cfg_i       = '0;
        cam_data_i  = '0;
        cam_hsync_i = 1'b0;
        cam_vsync_i = 1'b0;
        out_ready_i = 1'b1;
        err_word    = 0;
        err_flag    = 0;
        err_count   = 0;
        err_other   = 0;
        fill_table();
        repeat (10) @(negedge s_cam_clk_dft);
        rstn_i = 1'b1;
        check_flag(out_valid_o, 1'b0, "out_valid_o after reset");
        check_flag(frame_evt_o, 1'b0, "frame_evt_o after reset");
        check_flag(overflow_o, 1'b0, "overflow_o after reset");
        for (int i = 0; i < NUM_SCEN; i++) begin
            run_scenario(tbl[i], i);
        end
        $display("errors: %0d word, %0d flag, %0d count, %0d other",
                 err_word, err_flag, err_count, err_other);
        if (err_word + err_flag + err_count + err_other == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
common/cpi_pix_pkg.sv
common/cpi_cfg_pkg.sv
verilog/cpi_frame_ctrl.sv
verilog/cpi_sampler.sv
pixel_pipe/cpi_pixel_format.sv
pixel_pipe/cpi_luma_filter.sv
verilog/cpi_out_fifo.sv
verilog/cpi_top.sv
tb/cpi_tb_clkgen.sv
tb/cpi_tb.sv

// File: Bender.yml
package:
  name: cpi_rx

sources:
  - files:
      - common/cpi_pix_pkg.sv
      - common/cpi_cfg_pkg.sv
      - verilog/cpi_frame_ctrl.sv
      - verilog/cpi_sampler.sv
      - pixel_pipe/cpi_pixel_format.sv
      - pixel_pipe/cpi_luma_filter.sv
      - verilog/cpi_out_fifo.sv
      - verilog/cpi_top.sv
  - target: simulation
    files:
      - tb/cpi_tb_clkgen.sv
      - tb/cpi_tb.sv
